// File: list.f
rtl/imon_pkg.sv
rtl/imon_credit_if.sv
rtl/imon_in_fifo.sv
rtl/imon_credit_counter.sv
rtl/imon_bank_ctrl.sv
rtl/imon_ram.sv
rtl/imon_indirect_access.sv
rtl/imon_top.sv
testbench/imon_checker.sv
testbench/imon_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the capture buffer testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f list.f --top-module imon_tb -o imon_sim
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

out=$(./obj_dir/imon_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -q "PASS: all tests"; then
   exit 0
fi
exit 1

// File: testbench/imon_tb.sv
/*
 * Capture buffer testbench.
 * Drives capture, credit, bank and software traffic against a reference model.
 */
`timescale 1ns/100ps
`default_nettype none

module imon_tb;

   localparam int max_cycles = 4000;

   logic        clk = 1'b0;
   logic        rst_n = 1'b0;
   logic        im_vld = 1'b0;
   logic [31:0] im_din = '0;
   logic [1:0]  im_consumed = '0;
   logic [1:0]  mode = imon_pkg::mode_init;
   logic [4:0]  wr_credit_config = '0;
   logic        wr_stb = 1'b0;
   logic [3:0]  reg_addr = '0;
   logic [31:0] wr_dat = '0;
   logic [3:0]  cmnd_op = '0;
   logic [3:0]  cmnd_addr = '0;
   logic        im_rdy;
   logic [1:0]  im_available;
   logic        overflow;
   logic [3:0]  wr_pointer;
   logic [2:0]  stat_code;
   logic [31:0] rd_dat;
   logic        check_stb = 1'b0;
   logic [2:0]  check_test = '0;
   logic [2:0]  check_sig = '0;
   logic [31:0] check_exp = '0;

   logic [31:0] model_ram [16];
   logic [3:0]  model_addr = '0;
   logic        bank_on = 1'b0;
   int          seed = 75529;
   int          wait_errs = 0;
   int          cycles = 0;
   int          total;
   logic [31:0] sw_val;

   imon_top DUT (.*);

   imon_checker u_chk (.*);

   always #5 clk = ~clk;

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= max_cycles) begin
         $display("Timeout: run did not finish within %0d cycles", max_cycles);
         $display("FAIL: see errors above");
         $finish;
      end
   end

   // Address the next accepted word lands at.
   // In banked mode an end-of-burst word moves on to the base of the other bank.
   function automatic logic [3:0] ref_entry(input logic [3:0] addr, input logic banked,
                                            input logic eob);
      if (banked && eob) begin
         return addr[3] ? 4'd0 : 4'd8;
      end
      return addr + 4'd1;
   endfunction

   task automatic step(input int n);
      repeat (n) begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic check(input logic [2:0] t, input logic [2:0] s, input logic [31:0] e);
      check_test = t;
      check_sig  = s;
      check_exp  = e;
      check_stb  = 1'b1;
      step(1);
      check_stb  = 1'b0;
   endtask

   task automatic send_word(input logic [31:0] d, input logic record);
      if (record) begin
         model_ram[model_addr] = d;
         model_addr = ref_entry(model_addr, bank_on, d[31]);
      end
      im_vld = 1'b1;
      im_din = d;
      step(1);
      im_vld = 1'b0;
   endtask

   task automatic wait_ptr(input logic [3:0] exp);
      int n;
      n = 0;
      while (wr_pointer !== exp && n < 40) begin
         step(1);
         n++;
      end
      if (wr_pointer !== exp) begin
         $display("Write pointer never reached %0d", exp);
         wait_errs++;
      end
   endtask

   task automatic sw_cmd(input logic [3:0] op, input logic [3:0] addr);
      int n;
      reg_addr  = imon_pkg::cmnd_addr_reg;
      cmnd_op   = op;
      cmnd_addr = addr;
      wr_stb    = 1'b1;
      step(1);
      wr_stb = 1'b0;
      n = 0;
      while (stat_code == imon_pkg::stat_busy && n < 40) begin
         step(1);
         n++;
      end
      if (stat_code == imon_pkg::stat_busy) begin
         $display("Software command stayed busy at address %0d", addr);
         wait_errs++;
      end
   endtask

   task automatic sw_read_check(input logic [2:0] t, input logic [3:0] addr);
      sw_cmd(imon_pkg::cmd_read, addr);
      check(t, 3'd3, {29'd0, imon_pkg::stat_ok});
      check(t, 3'd4, model_ram[addr]);
   endtask

   task automatic pulse_consumed(input logic [1:0] b);
      im_consumed = b;
      step(1);
      im_consumed = 2'b00;
   endtask

   task automatic enter_init;
      mode = imon_pkg::mode_init;
      model_addr = '0;
      step(2);
   endtask

   initial begin
      step(10);
      rst_n = 1'b1;
      step(2);

      // ----------------------------------------
      // Per-entry capture with wrap.
      mode = imon_pkg::mode_single;
      wr_credit_config = 5'd16;
      step(1);
      for (int i = 0; i < 10; i++) begin
         send_word($random(seed), 1'b1);
      end
      wait_ptr(4'd9);
      check(3'd1, 3'd0, 32'd9);
      pulse_consumed(2'b01);
      for (int i = 0; i < 8; i++) begin
         send_word($random(seed), 1'b1);
      end
      wait_ptr(4'd1);
      check(3'd1, 3'd0, 32'd1);
      for (int a = 0; a < 16; a++) begin
         sw_read_check(3'd1, 4'(a));
      end

      // ----------------------------------------
      // Credit limit holds words in the FIFO.
      enter_init;
      mode = imon_pkg::mode_single;
      wr_credit_config = 5'd4;
      step(1);
      for (int i = 0; i < 6; i++) begin
         send_word($random(seed), 1'b1);
      end
      wait_ptr(4'd3);
      step(5);
      check(3'd2, 3'd0, 32'd3);
      pulse_consumed(2'b01);
      wait_ptr(4'd5);
      check(3'd2, 3'd0, 32'd5);
      sw_read_check(3'd2, 4'd4);
      sw_read_check(3'd2, 4'd5);

      // ----------------------------------------
      // Banked mode with an early close of bank 0, then of bank 1.
      enter_init;
      mode = imon_pkg::mode_bank;
      bank_on = 1'b1;
      wr_credit_config = 5'd8;
      step(2);
      send_word({1'b0, 31'($random(seed))}, 1'b1);
      send_word({1'b0, 31'($random(seed))}, 1'b1);
      send_word({1'b1, 31'($random(seed))}, 1'b1);
      send_word({1'b1, 31'($random(seed))}, 1'b1);
      wait_ptr(4'd2);
      step(4);
      check(3'd3, 3'd0, 32'd2);
      check(3'd3, 3'd1, 32'd1);
      pulse_consumed(2'b01);
      wait_ptr(4'd8);
      step(2);
      check(3'd3, 3'd1, 32'd2);
      check(3'd3, 3'd5, 32'd1);
      sw_read_check(3'd3, 4'd2);
      sw_read_check(3'd3, 4'd8);
      bank_on = 1'b0;

      // ----------------------------------------
      // Overflow with no credits, then init clears state.
      mode = imon_pkg::mode_single;
      wr_credit_config = 5'd0;
      step(2);
      for (int i = 0; i < 10; i++) begin
         send_word($random(seed), 1'b0);
      end
      step(2);
      check(3'd4, 3'd2, 32'd1);
      check(3'd4, 3'd0, 32'd8);
      check(3'd4, 3'd1, 32'd2);
      enter_init;
      check(3'd4, 3'd2, 32'd0);
      check(3'd4, 3'd0, 32'd0);
      check(3'd4, 3'd1, 32'd0);

      // ----------------------------------------
      // Software write, read back and a bad opcode.
      sw_val = $random(seed);
      model_ram[5] = sw_val;
      reg_addr = imon_pkg::data_addr_reg;
      wr_dat   = sw_val;
      wr_stb   = 1'b1;
      step(1);
      wr_stb = 1'b0;
      sw_cmd(imon_pkg::cmd_write, 4'd5);
      check(3'd5, 3'd3, {29'd0, imon_pkg::stat_ok});
      sw_read_check(3'd5, 4'd5);
      sw_cmd(4'd7, 4'd0);
      check(3'd5, 3'd3, {29'd0, imon_pkg::stat_err});

      step(2);
      total = u_chk.err_count + wait_errs;
      $display("Checks done with %0d errors", total);
      if (total == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: testbench/imon_checker.sv
/*
 * Capture buffer checker.
 * Samples a DUT output on request and compares it with the expected value.
 */
`timescale 1ns/100ps
`default_nettype none

module imon_checker (
   input logic        clk,
   input logic        rst_n,
   input logic        im_rdy,
   input logic [1:0]  im_available,
   input logic        overflow,
   input logic [3:0]  wr_pointer,
   input logic [2:0]  stat_code,
   input logic [31:0] rd_dat,
   input logic        check_stb,
   input logic [2:0]  check_test,
   input logic [2:0]  check_sig,
   input logic [31:0] check_exp
);

   int err_count = 0;

   function automatic string test_name(input logic [2:0] t);
      case (t)
         3'd1:    return "per_entry_capture";
         3'd2:    return "credit_limit";
         3'd3:    return "banked_mode";
         3'd4:    return "overflow";
         default: return "software_access";
      endcase
   endfunction

   function automatic string sig_name(input logic [2:0] s);
      case (s)
         3'd0:    return "wr_pointer";
         3'd1:    return "im_available";
         3'd2:    return "overflow";
         3'd3:    return "stat_code";
         3'd4:    return "rd_dat";
         default: return "im_rdy";
      endcase
   endfunction

   function automatic logic [31:0] pick(input logic [2:0] s);
      case (s)
         3'd0:    return {28'd0, wr_pointer};
         3'd1:    return {30'd0, im_available};
         3'd2:    return {31'd0, overflow};
         3'd3:    return {29'd0, stat_code};
         3'd4:    return rd_dat;
         default: return {31'd0, im_rdy};
      endcase
   endfunction

   // Outputs are registered, so the edge sees the values of the cycle before.
   always @(posedge clk) begin
      if (rst_n && check_stb && (pick(check_sig) !== check_exp)) begin
         err_count <= err_count + 1;
         $display("ERROR %s: %s expected 0x%0h, actual 0x%0h", test_name(check_test),
                  sig_name(check_sig), check_exp, pick(check_sig));
      end
   end

endmodule

`default_nettype wire

// File: rtl/imon_top.sv
/*
 * Interface monitor top level.
 * Input FIFO, credit-gated capture into RAM and software access.
 */
`timescale 1ns/100ps
`default_nettype none

module imon_top (
   input  logic                                clk,
   input  logic                                rst_n,
   input  logic                                im_vld,
   input  logic [imon_pkg::n_data_bits-1:0]    im_din,
   output logic                                im_rdy,
   output logic [1:0]                          im_available,
   input  logic [1:0]                          im_consumed,
   input  logic [1:0]                          mode,
   input  logic [imon_pkg::credit_bits-1:0]    wr_credit_config,
   output logic                                overflow,
   output logic [imon_pkg::addr_bits-1:0]      wr_pointer,
   input  logic                                wr_stb,
   input  logic [3:0]                          reg_addr,
   input  logic [31:0]                         wr_dat,
   input  logic [3:0]                          cmnd_op,
   input  logic [imon_pkg::addr_bits-1:0]      cmnd_addr,
   output logic [2:0]                          stat_code,
   output logic [31:0]                         rd_dat
);

   imon_pkg::imon_word_u in_word;
   imon_pkg::imon_word_u head;
   imon_pkg::imon_word_u hw_data;
   imon_pkg::imon_word_u sw_wdat;
   imon_pkg::imon_word_u ram_din;
   imon_pkg::imon_word_u ram_dout;

   logic [imon_pkg::addr_bits-1:0] hw_addr;
   logic [imon_pkg::addr_bits-1:0] sw_addr;
   logic [imon_pkg::addr_bits-1:0] ram_addr;
   logic [3:0] fifo_space;
   logic fifo_empty;
   logic fifo_full;
   logic pop;
   logic hw_we;
   logic sw_cs;
   logic sw_we;
   logic sw_waiting;
   logic ram_cs;
   logic ram_we;

   imon_credit_if cred ();

   assign in_word.raw = im_din;

   imon_in_fifo u_fifo (
      .clk   (clk),
      .rst_n (rst_n),
      .push  (im_vld),
      .din   (in_word),
      .pop   (pop),
      .dout  (head),
      .empty (fifo_empty),
      .full  (fifo_full),
      .space (fifo_space)
   );

   imon_credit_counter u_credit (
      .clk   (clk),
      .rst_n (rst_n),
      .clear (mode == imon_pkg::mode_init),
      .cred  (cred)
   );

   imon_bank_ctrl u_ctrl (
      .clk              (clk),
      .rst_n            (rst_n),
      .mode             (mode),
      .wr_credit_config (wr_credit_config),
      .head             (head),
      .fifo_empty       (fifo_empty),
      .fifo_full        (fifo_full),
      .fifo_space       (fifo_space),
      .im_vld           (im_vld),
      .im_consumed      (im_consumed),
      .sw_waiting       (sw_waiting),
      .cred             (cred),
      .pop              (pop),
      .hw_we            (hw_we),
      .hw_addr          (hw_addr),
      .hw_data          (hw_data),
      .im_rdy           (im_rdy),
      .im_available     (im_available),
      .overflow         (overflow),
      .wr_pointer       (wr_pointer)
   );

   // Hardware writes own the port; software gets the cycles in between.
   assign ram_cs   = hw_we | sw_cs;
   assign ram_we   = hw_we | sw_we;
   assign ram_addr = hw_we ? hw_addr : sw_addr;
   assign ram_din  = hw_we ? hw_data : sw_wdat;

   imon_ram u_ram (
      .clk  (clk),
      .cs   (ram_cs),
      .we   (ram_we),
      .addr (ram_addr),
      .din  (ram_din),
      .dout (ram_dout)
   );

   imon_indirect_access u_sw (
      .clk        (clk),
      .rst_n      (rst_n),
      .wr_stb     (wr_stb),
      .reg_addr   (reg_addr),
      .wr_dat     (wr_dat),
      .cmnd_op    (cmnd_op),
      .cmnd_addr  (cmnd_addr),
      .grant      (~hw_we),
      .ram_rdat   (ram_dout),
      .sw_cs      (sw_cs),
      .sw_we      (sw_we),
      .sw_addr    (sw_addr),
      .sw_wdat    (sw_wdat),
      .sw_waiting (sw_waiting),
      .stat_code  (stat_code),
      .rd_dat     (rd_dat)
   );

endmodule

`default_nettype wire

// File: rtl/imon_indirect_access.sv
/*
 * Software access engine.
 * Command and status registers for single reads and writes of the
 * capture RAM, using only cycles left free by hardware.
 */
`timescale 1ns/100ps
`default_nettype none

module imon_indirect_access (
   input  logic                              clk,
   input  logic                              rst_n,
   input  logic                              wr_stb,
   input  logic [3:0]                        reg_addr,
   input  logic [31:0]                       wr_dat,
   input  logic [3:0]                        cmnd_op,
   input  logic [imon_pkg::addr_bits-1:0]    cmnd_addr,
   input  logic                              grant,
   input  imon_pkg::imon_word_u              ram_rdat,
   output logic                              sw_cs,
   output logic                              sw_we,
   output logic [imon_pkg::addr_bits-1:0]    sw_addr,
   output imon_pkg::imon_word_u              sw_wdat,
   output logic                              sw_waiting,
   output logic [2:0]                        stat_code,
   output logic [31:0]                       rd_dat
);

   logic pend;
   logic rd_pend;
   logic op_write;
   logic busy;
   logic cmd_stb;
   logic [imon_pkg::addr_bits-1:0] addr_q;
   imon_pkg::imon_word_u           wdat_q;

   assign busy    = pend | rd_pend;
   assign cmd_stb = wr_stb && (reg_addr == imon_pkg::cmnd_addr_reg) && !busy;

   assign sw_cs      = pend & grant;
   assign sw_we      = sw_cs & op_write;
   assign sw_addr    = addr_q;
   assign sw_wdat    = wdat_q;
   assign sw_waiting = pend;

   always_ff @(posedge clk) begin
      if (wr_stb && (reg_addr == imon_pkg::data_addr_reg)) begin
         wdat_q.raw <= wr_dat;
      end
      if (cmd_stb) begin
         addr_q <= cmnd_addr;
      end
      if (rd_pend) begin
         rd_dat <= ram_rdat.raw;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pend      <= 1'b0;
         rd_pend   <= 1'b0;
         op_write  <= 1'b0;
         stat_code <= imon_pkg::stat_idle;
      end else begin
         rd_pend <= sw_cs & ~op_write;
         if (rd_pend) begin
            stat_code <= imon_pkg::stat_ok;
         end
         if (sw_cs) begin
            pend <= 1'b0;
            if (op_write) begin
               stat_code <= imon_pkg::stat_ok;
            end
         end
         if (cmd_stb) begin
            if ((cmnd_op == imon_pkg::cmd_read) || (cmnd_op == imon_pkg::cmd_write)) begin
               pend      <= 1'b1;
               op_write  <= (cmnd_op == imon_pkg::cmd_write);
               stat_code <= imon_pkg::stat_busy;
            end else begin
               stat_code <= imon_pkg::stat_err;
            end
         end else if (wr_stb && (reg_addr == imon_pkg::stat_addr_reg) && !busy) begin
            // Writing the status register acknowledges the last result.
            stat_code <= imon_pkg::stat_idle;
         end
      end
   end

   // An outstanding access reads as busy until its result lands.
   a_busy_status: assert property (@(posedge clk) disable iff (!rst_n)
      busy |-> (stat_code == imon_pkg::stat_busy))
      else $error("software access outstanding while status is not busy");

endmodule

`default_nettype wire

// File: rtl/imon_ram.sv
/*
 * Capture RAM, 16 x 32, single port with registered read data.
 */
`timescale 1ns/100ps
`default_nettype none

module imon_ram (
   input  logic                             clk,
   input  logic                             cs,
   input  logic                             we,
   input  logic [imon_pkg::addr_bits-1:0]   addr,
   input  imon_pkg::imon_word_u             din,
   output imon_pkg::imon_word_u             dout
);

   imon_pkg::imon_word_u mem [imon_pkg::n_entries];

   // Read data changes only on a read access.
   always_ff @(posedge clk) begin
      if (cs) begin
         if (we) begin
            mem[addr] <= din;
         end else begin
            dout <= mem[addr];
         end
      end
   end

endmodule

`default_nettype wire

// File: rtl/imon_bank_ctrl.sv
/*
 * Capture bank controller.
 * Drains the input FIFO into RAM against write credits, closes banks,
 * announces them to the consumer and keeps the overflow flag.
 */
`timescale 1ns/100ps
`default_nettype none

module imon_bank_ctrl (
   input  logic                                clk,
   input  logic                                rst_n,
   input  logic [1:0]                          mode,
   input  logic [imon_pkg::credit_bits-1:0]    wr_credit_config,
   input  imon_pkg::imon_word_u                head,
   input  logic                                fifo_empty,
   input  logic                                fifo_full,
   input  logic [3:0]                          fifo_space,
   input  logic                                im_vld,
   input  logic [1:0]                          im_consumed,
   input  logic                                sw_waiting,
   imon_credit_if.ctrl                         cred,
   output logic                                pop,
   output logic                                hw_we,
   output logic [imon_pkg::addr_bits-1:0]      hw_addr,
   output imon_pkg::imon_word_u                hw_data,
   output logic                                im_rdy,
   output logic [1:0]                          im_available,
   output logic                                overflow,
   output logic [imon_pkg::addr_bits-1:0]      wr_pointer
);

   logic [1:0] state;
   logic [1:0] state_nxt;
   logic [1:0] closed;
   logic [1:0] close_set;
   logic [1:0] consumed_q;
   logic [imon_pkg::addr_bits-1:0]   wr_addr;
   logic [imon_pkg::addr_bits-1:0]   next_base;
   logic [imon_pkg::credit_bits-1:0] offset_c;
   logic [imon_pkg::credit_bits-1:0] use_cnt;
   logic bank_mode;
   logic early_close;
   logic closing;
   logic rdy_nxt;

   assign bank_mode   = (state == imon_pkg::st_fill_bank0) || (state == imon_pkg::st_fill_bank1);
   assign early_close = bank_mode & head.desc.eob;
   assign closing     = early_close || (wr_addr[imon_pkg::addr_bits-2:0] == '1);
   assign next_base   = (state == imon_pkg::st_fill_bank0) ? imon_pkg::bank1_base : '0;

   always_comb begin
      offset_c = '0;
      offset_c[imon_pkg::addr_bits-2:0] = wr_addr[imon_pkg::addr_bits-2:0];
   end

   // An early close spends every credit left in the bank.
   assign use_cnt = early_close ? (imon_pkg::half_credits - offset_c) : imon_pkg::one_credit;

   assign hw_we = ~fifo_empty && (mode != imon_pkg::mode_init) &&
                  (state != imon_pkg::st_init) && (cred.credit_available >= use_cnt);
   assign pop     = hw_we;
   assign hw_addr = wr_addr;
   assign hw_data = head;

   // ----------------------------------------
   // Credit exchange.
   assign cred.credit_limit  = (wr_credit_config > imon_pkg::max_credits) ?
                               imon_pkg::max_credits : wr_credit_config;
   assign cred.credit_used   = hw_we ? use_cnt : '0;
   assign cred.credit_return = (consumed_q[0] ? imon_pkg::half_credits : '0) +
                               (consumed_q[1] ? imon_pkg::half_credits : '0);

   always_comb begin
      close_set = '0;
      if (hw_we && closing) begin
         close_set[wr_addr[imon_pkg::addr_bits-1]] = 1'b1;
      end
   end

   always_comb begin
      case (mode)
         imon_pkg::mode_init: state_nxt = imon_pkg::st_init;
         imon_pkg::mode_bank: begin
            if (!bank_mode) begin
               state_nxt = wr_addr[imon_pkg::addr_bits-1] ? imon_pkg::st_fill_bank1 :
                                                           imon_pkg::st_fill_bank0;
            end else if (hw_we && closing) begin
               state_nxt = (state == imon_pkg::st_fill_bank0) ? imon_pkg::st_fill_bank1 :
                                                                imon_pkg::st_fill_bank0;
            end else begin
               state_nxt = state;
            end
         end
         default: state_nxt = imon_pkg::st_idle;
      endcase
   end

   always_comb begin
      case (mode)
         imon_pkg::mode_bank: rdy_nxt = (fifo_space > 4'(imon_pkg::in_flight_margin)) &&
                                        !sw_waiting;
         imon_pkg::mode_init: rdy_nxt = 1'b0;
         default:             rdy_nxt = 1'b1;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state        <= imon_pkg::st_idle;
         wr_addr      <= '0;
         wr_pointer   <= '0;
         closed       <= '0;
         consumed_q   <= '0;
         im_available <= '0;
         overflow     <= 1'b0;
         im_rdy       <= 1'b0;
      end else begin
         state        <= state_nxt;
         consumed_q   <= im_consumed;
         im_available <= closed;
         im_rdy       <= rdy_nxt;
         if (mode == imon_pkg::mode_init) begin
            wr_addr    <= '0;
            wr_pointer <= '0;
            closed     <= '0;
            overflow   <= 1'b0;
         end else begin
            overflow <= overflow | (im_vld & fifo_full);
            closed   <= (closed & ~consumed_q) | close_set;
            if (hw_we) begin
               wr_pointer <= wr_addr;
               if (early_close) begin
                  wr_addr <= next_base;
               end else begin
                  wr_addr <= wr_addr + 1'b1;
               end
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: rtl/imon_credit_counter.sv
/*
 * Write credit counter.
 * Tracks credits in use against the configured limit.
 */
`timescale 1ns/100ps
`default_nettype none

module imon_credit_counter (
   input logic             clk,
   input logic             rst_n,
   input logic             clear,
   imon_credit_if.counter  cred
);

   logic [imon_pkg::credit_bits-1:0] issued;
   logic [imon_pkg::credit_bits-1:0] sum;
   logic [imon_pkg::credit_bits-1:0] issued_nxt;

   assign sum = issued + cred.credit_used;

   // A return larger than what is out only empties the count.
   always_comb begin
      if (cred.credit_return > sum) begin
         issued_nxt = '0;
      end else begin
         issued_nxt = sum - cred.credit_return;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         issued <= '0;
      end else if (clear) begin
         issued <= '0;
      end else begin
         issued <= issued_nxt;
      end
   end

   assign cred.credit_issued = issued;

   always_comb begin
      if (cred.credit_limit > issued) begin
         cred.credit_available = cred.credit_limit - issued;
      end else begin
         cred.credit_available = '0;
      end
   end

   // The controller clamps the limit and never spends more than is available,
   // so the count can never pass the number of RAM entries.
   a_issued_in_range: assert property (@(posedge clk) disable iff (!rst_n)
      issued <= imon_pkg::max_credits)
      else $error("credit_issued above RAM size: %0d", issued);

endmodule

`default_nettype wire

// File: rtl/imon_in_fifo.sv
/*
 * Input FIFO for captured words.
 * Show-ahead, eight deep, reports free space for the ready logic.
 */
`timescale 1ns/100ps
`default_nettype none

module imon_in_fifo (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 push,
   input  imon_pkg::imon_word_u din,
   input  logic                 pop,
   output imon_pkg::imon_word_u dout,
   output logic                 empty,
   output logic                 full,
   output logic [3:0]           space
);

   imon_pkg::imon_word_u mem [imon_pkg::fifo_depth];

   logic [$clog2(imon_pkg::fifo_depth)-1:0] wr_ptr;
   logic [$clog2(imon_pkg::fifo_depth)-1:0] rd_ptr;
   logic [3:0] count;
   logic       do_push;
   logic       do_pop;

   assign do_push = push & ~full;
   assign do_pop  = pop & ~empty;

   assign empty = (count == 4'd0);
   assign full  = (count == 4'(imon_pkg::fifo_depth));
   assign space = 4'(imon_pkg::fifo_depth) - count;
   assign dout  = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= din;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         count <= count + {3'd0, do_push} - {3'd0, do_pop};
      end
   end

   // The bank controller must only pop a word it can see at the head.
   a_no_pop_when_empty: assert property (@(posedge clk) disable iff (!rst_n)
      pop |-> !empty)
      else $error("FIFO popped while empty");

endmodule

`default_nettype wire

// File: rtl/imon_credit_if.sv
/*
 * Write credit channel between the bank controller and the credit counter.
 */
`timescale 1ns/100ps
`default_nettype none

interface imon_credit_if;

   logic [imon_pkg::credit_bits-1:0] credit_limit;
   logic [imon_pkg::credit_bits-1:0] credit_used;
   logic [imon_pkg::credit_bits-1:0] credit_return;
   logic [imon_pkg::credit_bits-1:0] credit_issued;
   logic [imon_pkg::credit_bits-1:0] credit_available;

   modport ctrl (
      output credit_limit,
      output credit_used,
      output credit_return,
      input  credit_issued,
      input  credit_available
   );

   modport counter (
      input  credit_limit,
      input  credit_used,
      input  credit_return,
      output credit_issued,
      output credit_available
   );

endinterface

`default_nettype wire

// File: rtl/imon_pkg.sv
/*
 * Interface monitor shared definitions.
 * Sizes, mode and register codes, status codes and the capture word.
 */
`default_nettype none

package imon_pkg;

   localparam int n_entries        = 16;
   localparam int n_half           = 8;
   localparam int n_data_bits      = 32;
   localparam int addr_bits        = 4;
   localparam int credit_bits      = 5;
   localparam int fifo_depth       = 8;
   localparam int in_flight_margin = 2;

   // Code 01 is not decoded and runs as per-entry capture.
   localparam logic [1:0] mode_single = 2'b00;
   localparam logic [1:0] mode_bank   = 2'b10;
   localparam logic [1:0] mode_init   = 2'b11;

   localparam logic [3:0] cmnd_addr_reg = 4'd0;
   localparam logic [3:0] stat_addr_reg = 4'd1;
   localparam logic [3:0] data_addr_reg = 4'd2;

   localparam logic [3:0] cmd_read  = 4'd1;
   localparam logic [3:0] cmd_write = 4'd2;

   localparam logic [2:0] stat_idle = 3'd0;
   localparam logic [2:0] stat_busy = 3'd1;
   localparam logic [2:0] stat_ok   = 3'd2;
   localparam logic [2:0] stat_err  = 3'd3;

   // ----------------------------------------
   // Bank controller states and credit constants.
   localparam logic [1:0] st_idle       = 2'd0;
   localparam logic [1:0] st_fill_bank0 = 2'd1;
   localparam logic [1:0] st_fill_bank1 = 2'd2;
   localparam logic [1:0] st_init       = 2'd3;

   localparam logic [credit_bits-1:0] one_credit   = 1;
   localparam logic [credit_bits-1:0] half_credits = credit_bits'(n_half);
   localparam logic [credit_bits-1:0] max_credits  = credit_bits'(n_entries);
   localparam logic [addr_bits-1:0]   bank1_base   = addr_bits'(n_half);

   // The bank controller reads the word as a descriptor, everyone else as raw bits.
   typedef union packed {
      logic [n_data_bits-1:0] raw;
      struct packed {
         logic        eob;
         logic [6:0]  tag;
         logic [23:0] payload;
      } desc;
   } imon_word_u;

endpackage

`default_nettype wire
